/* cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and register file widths
`define DBITS 32
`define REGNO_BITS 4
`define IMM_BITS 16
`define OP1_BITS 6
`define OP2_BITS 8

// first fetch address after reset
`define START_PC 32'h0000_0100

// memory mapped hex display register
`define ADDR_HEX 32'hFFFF_F000
`define HEX_BITS 24
`define HEX_RESET 24'hFEDEAD

// data memory is byte addressed, word indexed
`define DMEM_ADDR_BITS 16
`define DMEM_WORD_BITS 2

// all-zero word, decodes as ALUR with an unused op2
`define NOP_INST 32'h0000_0000

// instruction field positions (lsb of each field)
`define OP1_LSB 26
`define OP2_LSB 18
`define IMM_LSB 8
`define RD_LSB 8
`define RS_LSB 4
`define RT_LSB 0

`endif

/* cpu_pkg.sv */
`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`DBITS-1:0] word_t;
  typedef logic [`REGNO_BITS-1:0] regno_t;
  typedef logic [`HEX_BITS-1:0] hex_t;

  // primary opcode, inst[31:26]
  typedef enum logic [`OP1_BITS-1:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // secondary opcode for ALUR, inst[25:18]
  typedef enum logic [`OP2_BITS-1:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  typedef struct packed {
    logic is_br;
    logic is_jmp;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  // fetch -> decode
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } fe_id_t;

  // decode -> execute
  typedef struct packed {
    logic   valid;
    word_t  pc;
    op1_e   op1;
    op2_e   op2;
    word_t  regval1;
    word_t  regval2;
    word_t  immval;
    regno_t wregno;
    ctrl_t  ctrl;
  } id_ex_t;

  // execute -> memory, enables already qualified by valid
  typedef struct packed {
    logic   valid;
    word_t  aluout;
    word_t  regval2;
    regno_t wregno;
    logic   rd_mem;
    logic   wr_mem;
    logic   wr_reg;
  } ex_mem_t;

  // memory -> register file write port
  typedef struct packed {
    logic   wr_reg;
    regno_t wregno;
    word_t  regval;
  } mem_wb_t;

endpackage

/* fetch_stage.sv */
`include "cpu_consts.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   stall,
  input  logic   redirect,
  input  word_t  redirect_pc,
  output word_t  imem_addr,
  input  word_t  imem_rdata,
  output fe_id_t fe_id
);

  word_t pc;
  word_t pc_next;

  // predict not-taken, so the next pc is always pc + 4
  // redirect from EX wins over a decode stall
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `START_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // instruction port is combinational, data is back in the same cycle
  assign imem_addr = pc;

  // fetch latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fe_id <= '{valid: 1'b0, pc: `START_PC, inst: `NOP_INST};
    end else if (redirect) begin
      // younger instruction on the wrong path
      fe_id.valid <= 1'b0;
    end else if (!stall) begin
      fe_id.valid <= 1'b1;
      fe_id.pc    <= pc;
      fe_id.inst  <= imem_rdata;
    end
  end

  // a misaligned jal target would show up here
  pc_aligned_a: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("fetch pc not word aligned: %h", pc);

endmodule

/* reg_file.sv */
`include "cpu_consts.svh"

module reg_file import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  regno_t  rs,
  input  regno_t  rt,
  output word_t   rs_val,
  output word_t   rt_val,
  input  mem_wb_t wb
);

  localparam int NREGS = 1 << `REGNO_BITS;

  word_t regs [NREGS];

  // write on the rising edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wr_reg) begin
      regs[wb.wregno] <= wb.regval;
    end
  end

  // bypass the value being written this cycle
  // so decode never has to wait on write-back
  assign rs_val = (wb.wr_reg && (wb.wregno == rs)) ? wb.regval : regs[rs];
  assign rt_val = (wb.wr_reg && (wb.wregno == rt)) ? wb.regval : regs[rt];

endmodule

/* decode_stage.sv */
`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  fe_id_t  fe_id,
  input  logic    redirect,
  input  ex_mem_t ex_mem,
  input  mem_wb_t wb,
  output logic    stall,
  output id_ex_t  id_ex
);

  op1_e                 op1;
  op2_e                 op2;
  logic [`IMM_BITS-1:0] imm;
  regno_t               rd;
  regno_t               rs;
  regno_t               rt;
  word_t                rs_val;
  word_t                rt_val;
  logic                 op2_ok;
  logic                 use_rs;
  logic                 use_rt;
  ctrl_t                ctrl;
  regno_t               wregno;
  logic                 hit_ex;
  logic                 hit_mem;

  // field extraction, imm and rd overlap on purpose
  assign op1 = op1_e'(fe_id.inst[`OP1_LSB +: `OP1_BITS]);
  assign op2 = op2_e'(fe_id.inst[`OP2_LSB +: `OP2_BITS]);
  assign imm = fe_id.inst[`IMM_LSB +: `IMM_BITS];
  assign rd  = fe_id.inst[`RD_LSB +: `REGNO_BITS];
  assign rs  = fe_id.inst[`RS_LSB +: `REGNO_BITS];
  assign rt  = fe_id.inst[`RT_LSB +: `REGNO_BITS];

  reg_file u_reg_file (
    .clk    (clk),
    .reset  (reset),
    .rs     (rs),
    .rt     (rt),
    .rs_val (rs_val),
    .rt_val (rt_val),
    .wb     (wb)
  );

  // unknown op2 codes (the all-zero nop among them) write nothing
  always_comb begin
    case (op2)
      OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
      OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR, OP2_NXOR, OP2_RSHF,
      OP2_LSHF: op2_ok = 1'b1;
      default:  op2_ok = 1'b0;
    endcase
  end

  // control, source usage and destination per primary opcode
  always_comb begin
    ctrl   = '0;
    use_rs = 1'b0;
    use_rt = 1'b0;
    wregno = rd;
    case (op1)
      OP1_ALUR: begin
        ctrl.wr_reg = op2_ok;
        use_rs      = op2_ok;
        use_rt      = op2_ok;
      end
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: begin
        ctrl.wr_reg = 1'b1;
        use_rs      = 1'b1;
        wregno      = rt;
      end
      OP1_LW: begin
        ctrl.rd_mem = 1'b1;
        ctrl.wr_reg = 1'b1;
        use_rs      = 1'b1;
        wregno      = rt;
      end
      OP1_SW: begin
        // rt carries the store data
        ctrl.wr_mem = 1'b1;
        use_rs      = 1'b1;
        use_rt      = 1'b1;
      end
      OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: begin
        ctrl.is_br = 1'b1;
        use_rs     = 1'b1;
        use_rt     = 1'b1;
      end
      OP1_JAL: begin
        // link goes to rt, target base comes from rs
        ctrl.is_jmp = 1'b1;
        ctrl.wr_reg = 1'b1;
        use_rs      = 1'b1;
        wregno      = rt;
      end
      default: ;
    endcase
  end

  // pending writes: instruction now in EX (our own latch) and the one in MEM
  // WB is covered by the register file bypass
  assign hit_ex  = id_ex.valid && id_ex.ctrl.wr_reg &&
                   ((use_rs && (id_ex.wregno == rs)) || (use_rt && (id_ex.wregno == rt)));
  assign hit_mem = ex_mem.valid && ex_mem.wr_reg &&
                   ((use_rs && (ex_mem.wregno == rs)) || (use_rt && (ex_mem.wregno == rt)));
  assign stall   = fe_id.valid && (hit_ex || hit_mem);

  // decode latch, bubble on stall, flush or empty slot
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else if (redirect || stall || !fe_id.valid) begin
      id_ex <= '0;
    end else begin
      id_ex.valid   <= 1'b1;
      id_ex.pc      <= fe_id.pc;
      id_ex.op1     <= op1;
      id_ex.op2     <= op2;
      id_ex.regval1 <= rs_val;
      id_ex.regval2 <= rt_val;
      id_ex.immval  <= {{(`DBITS-`IMM_BITS){imm[`IMM_BITS-1]}}, imm};
      id_ex.wregno  <= wregno;
      id_ex.ctrl    <= ctrl;
    end
  end

  // a producer in EX reaches WB within two cycles
  // bubbles fill EX and MEM behind it, so a third stall cycle means a lost hazard
  stall_bound_a: assert property (@(posedge clk) disable iff (reset)
    stall ##1 stall |=> !stall)
    else $error("decode stalled for more than two cycles in a row");

endmodule

/* execute_stage.sv */
`include "cpu_consts.svh"

module execute_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  id_ex_t  id_ex,
  output logic    redirect,
  output word_t   redirect_pc,
  output ex_mem_t ex_mem
);

  logic signed [`DBITS-1:0] sa;
  logic signed [`DBITS-1:0] sb;
  word_t                    aluout;
  logic                     br_cond;
  word_t                    pc_plus4;
  word_t                    imm_x4;

  // all compares and the right shift are signed
  assign sa = id_ex.regval1;
  assign sb = id_ex.regval2;

  assign pc_plus4 = id_ex.pc + 32'd4;
  assign imm_x4   = id_ex.immval << 2;

  always_comb begin
    aluout = '0;
    case (id_ex.op1)
      OP1_ALUR: begin
        case (id_ex.op2)
          OP2_EQ:   aluout = {{(`DBITS-1){1'b0}}, sa == sb};
          OP2_LT:   aluout = {{(`DBITS-1){1'b0}}, sa < sb};
          OP2_LE:   aluout = {{(`DBITS-1){1'b0}}, sa <= sb};
          OP2_NE:   aluout = {{(`DBITS-1){1'b0}}, sa != sb};
          OP2_ADD:  aluout = sa + sb;
          OP2_AND:  aluout = sa & sb;
          OP2_OR:   aluout = sa | sb;
          OP2_XOR:  aluout = sa ^ sb;
          OP2_SUB:  aluout = sa - sb;
          OP2_NAND: aluout = ~(sa & sb);
          OP2_NOR:  aluout = ~(sa | sb);
          OP2_NXOR: aluout = ~(sa ^ sb);
          // shift amount is the whole unsigned rt value
          OP2_RSHF: aluout = sa >>> id_ex.regval2;
          OP2_LSHF: aluout = id_ex.regval1 << id_ex.regval2;
          default:  aluout = '0;
        endcase
      end
      // loads and stores use the adder for the address
      OP1_ADDI, OP1_LW, OP1_SW: aluout = id_ex.regval1 + id_ex.immval;
      OP1_ANDI: aluout = id_ex.regval1 & id_ex.immval;
      OP1_ORI:  aluout = id_ex.regval1 | id_ex.immval;
      OP1_XORI: aluout = id_ex.regval1 ^ id_ex.immval;
      // link value
      OP1_JAL:  aluout = pc_plus4;
      default:  aluout = '0;
    endcase
  end

  always_comb begin
    case (id_ex.op1)
      OP1_BEQ: br_cond = (sa == sb);
      OP1_BLT: br_cond = (sa < sb);
      OP1_BLE: br_cond = (sa <= sb);
      OP1_BNE: br_cond = (sa != sb);
      default: br_cond = 1'b0;
    endcase
  end

  // not-taken prediction, so any taken branch or jal is a mispredict
  assign redirect    = id_ex.valid && ((id_ex.ctrl.is_br && br_cond) || id_ex.ctrl.is_jmp);
  assign redirect_pc = id_ex.ctrl.is_jmp ? (id_ex.regval1 + imm_x4) : (pc_plus4 + imm_x4);

  // execute latch, enables qualified by valid
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid   <= id_ex.valid;
      ex_mem.aluout  <= aluout;
      ex_mem.regval2 <= id_ex.regval2;
      ex_mem.wregno  <= id_ex.wregno;
      ex_mem.rd_mem  <= id_ex.valid && id_ex.ctrl.rd_mem;
      ex_mem.wr_mem  <= id_ex.valid && id_ex.ctrl.wr_mem;
      ex_mem.wr_reg  <= id_ex.valid && id_ex.ctrl.wr_reg;
    end
  end

endmodule

/* memory_stage.sv */
`include "cpu_consts.svh"

module memory_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  output hex_t    hex,
  output mem_wb_t wb
);

  localparam int IDX_BITS   = `DMEM_ADDR_BITS - `DMEM_WORD_BITS;
  localparam int DMEM_WORDS = 1 << IDX_BITS;

  word_t                dmem [DMEM_WORDS];
  logic [IDX_BITS-1:0]  dmem_idx;
  logic                 is_hex;
  word_t                load_data;

  // word index from the byte address, upper bits ignored
  assign dmem_idx = ex_mem.aluout[`DMEM_ADDR_BITS-1:`DMEM_WORD_BITS];
  assign is_hex   = (ex_mem.aluout == `ADDR_HEX);

  // hex store does not touch the data memory
  always_ff @(posedge clk) begin
    if (ex_mem.wr_mem && !is_hex) begin
      dmem[dmem_idx] <= ex_mem.regval2;
    end
  end

  assign load_data = dmem[dmem_idx];

  // hex display register, low 24 bits of the store data
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex <= `HEX_RESET;
    end else if (ex_mem.wr_mem && is_hex) begin
      hex <= ex_mem.regval2[`HEX_BITS-1:0];
    end
  end

  // write-back latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.wr_reg <= ex_mem.wr_reg;
      wb.wregno <= ex_mem.wregno;
      wb.regval <= ex_mem.rd_mem ? load_data : ex_mem.aluout;
    end
  end

  // decode never sets both for one opcode
  rd_wr_excl_a: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.rd_mem && ex_mem.wr_mem))
    else $error("load and store enabled together in MEM");

endmodule

/* cpu_top.sv */
module cpu_top import cpu_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  output word_t imem_addr,
  input  word_t imem_rdata,
  output hex_t  hex
);

  fe_id_t  fe_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t wb;
  logic    stall;
  logic    redirect;
  word_t   redirect_pc;

  fetch_stage u_fetch (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_addr   (imem_addr),
    .imem_rdata  (imem_rdata),
    .fe_id       (fe_id)
  );

  // register file lives in decode, written back from the MEM latch
  decode_stage u_decode (
    .clk      (clk),
    .reset    (reset),
    .fe_id    (fe_id),
    .redirect (redirect),
    .ex_mem   (ex_mem),
    .wb       (wb),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  execute_stage u_execute (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem)
  );

  memory_stage u_memory (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .hex    (hex),
    .wb     (wb)
  );

endmodule

/* tb_cpu.sv */
`include "cpu_consts.svh"

module tb_cpu import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED = 32'h5fd6_0891;
  localparam int RUN_LIMIT = 3000;
  localparam int QUIET_CYCLES = 40;
  // r0 plus this sign-extended offset lands on the hex register
  localparam logic [15:0] HEX_OFS = 16'(`ADDR_HEX);

  logic  clk = 1'b0;
  logic  reset;
  word_t imem_addr;
  word_t imem_rdata;
  hex_t  hex;

  // instruction memory model, keyed by word address
  word_t imem [word_t];
  int    prog_gen = 0;
  word_t prog_pc;
  hex_t  exp_hex [$];
  int    marker_idx;

  int check_count = 0;
  int mismatch_count = 0;
  int fail_count = 0;

  cpu_top dut (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .hex        (hex)
  );

  always #5 clk = ~clk;

  // prog_gen bumps on every new program so the read re-evaluates
  always_comb begin
    if (prog_gen != 0 && imem.exists(imem_addr >> 2)) begin
      imem_rdata = imem[imem_addr >> 2];
    end else begin
      imem_rdata = `NOP_INST;
    end
  end

  function automatic word_t encode_alur(op2_e op2, regno_t rd, regno_t rs, regno_t rt);
    word_t w;
    w = '0;
    w[`OP1_LSB +: `OP1_BITS] = OP1_ALUR;
    w[`OP2_LSB +: `OP2_BITS] = op2;
    w[`RD_LSB +: `REGNO_BITS] = rd;
    w[`RS_LSB +: `REGNO_BITS] = rs;
    w[`RT_LSB +: `REGNO_BITS] = rt;
    return w;
  endfunction

  function automatic word_t encode_imm(op1_e op1, regno_t rt, regno_t rs, logic [15:0] imm);
    word_t w;
    w = '0;
    w[`OP1_LSB +: `OP1_BITS] = op1;
    w[`IMM_LSB +: `IMM_BITS] = imm;
    w[`RS_LSB +: `REGNO_BITS] = rs;
    w[`RT_LSB +: `REGNO_BITS] = rt;
    return w;
  endfunction

  // expected R-type result, signed compares and arithmetic right shift
  function automatic word_t alur_ref(op2_e op, word_t a, word_t b);
    case (op)
      OP2_EQ:   return (a == b) ? 32'd1 : 32'd0;
      OP2_LT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP2_LE:   return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      OP2_NE:   return (a != b) ? 32'd1 : 32'd0;
      OP2_ADD:  return a + b;
      OP2_AND:  return a & b;
      OP2_OR:   return a | b;
      OP2_XOR:  return a ^ b;
      OP2_SUB:  return a - b;
      OP2_NAND: return ~(a & b);
      OP2_NOR:  return ~(a | b);
      OP2_NXOR: return ~(a ^ b);
      OP2_RSHF: return word_t'($signed(a) >>> b);
      OP2_LSHF: return a << b;
      default:  return '0;
    endcase
  endfunction

  function automatic word_t imm_ref(op1_e op, word_t a, logic [15:0] imm);
    word_t x;
    x = {{16{imm[15]}}, imm};
    case (op)
      OP1_ADDI: return a + x;
      OP1_ANDI: return a & x;
      OP1_ORI:  return a | x;
      default:  return a ^ x;
    endcase
  endfunction

  function automatic bit branch_taken(op1_e op, word_t a, word_t b);
    case (op)
      OP1_BEQ: return a == b;
      OP1_BLT: return $signed(a) < $signed(b);
      OP1_BLE: return $signed(a) <= $signed(b);
      default: return a != b;
    endcase
  endfunction

  task automatic check_hex(string sig, hex_t got, hex_t exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, sig, got, exp);
    end
  endtask

  task automatic check_addr(string sig, word_t got, word_t exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, sig, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic emit(word_t inst);
    imem[prog_pc >> 2] = inst;
    prog_pc += 4;
  endtask

  // r15 holds the shift count that load_reg needs
  task automatic begin_program();
    imem.delete();
    exp_hex.delete();
    prog_pc = `START_PC;
    marker_idx = 0;
    emit(encode_imm(OP1_ADDI, 15, 0, 16'd16));
  endtask

  task automatic load_reg(regno_t r, word_t v);
    logic [15:0] hi;
    logic [15:0] lo;
    lo = v[15:0];
    // low add sign-extends, pre-correct the high half
    hi = v[31:16] + {15'b0, lo[15]};
    emit(encode_imm(OP1_ADDI, r, 0, hi));
    emit(encode_alur(OP2_LSHF, r, r, 15));
    emit(encode_imm(OP1_ADDI, r, r, lo));
  endtask

  task automatic expect_store(regno_t r, word_t value);
    emit(encode_imm(OP1_SW, r, 0, HEX_OFS));
    exp_hex.push_back(value[`HEX_BITS-1:0]);
  endtask

  // distinct value before each result, so equal results still change hex
  task automatic emit_marker();
    emit(encode_imm(OP1_ADDI, 5, 0, 16'h7A00 + 16'(marker_idx)));
    expect_store(5, 32'h7A00 + marker_idx);
    marker_idx++;
  endtask

  // reset, then compare each hex change against the expected list
  task automatic run_program(string name);
    hex_t last;
    int   got_n;
    int   waited;
    prog_gen++;
    apply_reset();
    last = `HEX_RESET;
    got_n = 0;
    waited = 0;
    while (got_n < exp_hex.size() && waited < RUN_LIMIT) begin
      @(negedge clk);
      waited++;
      if (hex !== last) begin
        check_hex($sformatf("hex[%s %0d]", name, got_n), hex, exp_hex[got_n]);
        last = hex;
        got_n++;
      end
    end
    if (got_n < exp_hex.size()) begin
      fail_count++;
      $display("%s: timed out after %0d cycles, saw %0d of %0d hex updates",
               name, waited, got_n, exp_hex.size());
    end else begin
      // nothing may follow, flushed stores included
      waited = 0;
      while (waited < QUIET_CYCLES) begin
        @(negedge clk);
        waited++;
        if (hex !== last) begin
          fail_count++;
          $display("%s: unexpected hex update to %h after the last expected store", name, hex);
          last = hex;
        end
      end
    end
  endtask

  task automatic test_reset();
    imem.delete();
    prog_gen++;
    apply_reset();
    @(negedge clk);
    check_hex("hex", hex, `HEX_RESET);
    check_addr("imem_addr", imem_addr, `START_PC);
  endtask

  // each result stored right after it is computed, forcing a stall
  task automatic test_alur();
    word_t a;
    word_t b;
    word_t s;
    op2_e  op;
    int    round;
    begin_program();
    for (round = 0; round < 2; round++) begin
      a = $urandom();
      // second round has equal operands
      b = (round == 0) ? $urandom() : a;
      s = $urandom_range(31, 0);
      load_reg(1, a);
      load_reg(2, b);
      load_reg(3, s);
      op = op.first();
      do begin
        emit_marker();
        if (op == OP2_RSHF || op == OP2_LSHF) begin
          emit(encode_alur(op, 4, 1, 3));
          expect_store(4, alur_ref(op, a, s));
        end else begin
          emit(encode_alur(op, 4, 1, 2));
          expect_store(4, alur_ref(op, a, b));
        end
        op = op.next();
      end while (op != op.first());
    end
    run_program("alur");
  endtask

  task automatic test_imm();
    word_t       a;
    logic [15:0] imm;
    op1_e        ops [4];
    int          i;
    int          k;
    ops = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
    begin_program();
    a = $urandom();
    load_reg(1, a);
    for (k = 0; k < 3; k++) begin
      // negative immediates only
      imm = 16'h8000 | 16'($urandom());
      for (i = 0; i < 4; i++) begin
        emit_marker();
        emit(encode_imm(ops[i], 4, 1, imm));
        expect_store(4, imm_ref(ops[i], a, imm));
      end
    end
    run_program("imm");
  endtask

  task automatic test_mem();
    word_t       vals [4];
    logic [15:0] addrs [4];
    int          k;
    begin_program();
    for (k = 0; k < 4; k++) begin
      vals[k] = $urandom();
      // separate 4 KB windows keep the addresses distinct
      addrs[k] = 16'(k * 32'h1000 + $urandom_range(32'h3FF, 0) * 4);
      load_reg(1, vals[k]);
      emit(encode_imm(OP1_SW, 1, 0, addrs[k]));
    end
    // read back in reverse order, load-use stall on the store
    for (k = 3; k >= 0; k--) begin
      emit_marker();
      emit(encode_imm(OP1_LW, 4, 0, addrs[k]));
      expect_store(4, vals[k]);
    end
    run_program("mem");
  endtask

  task automatic test_branch();
    word_t  regv [1:2];
    op1_e   brs [4];
    regno_t rs_sel [3];
    regno_t rt_sel [3];
    word_t  jal_pc;
    int     i;
    int     p;
    int     idx;
    brs = '{OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE};
    rs_sel = '{4'd1, 4'd2, 4'd1};
    rt_sel = '{4'd2, 4'd1, 4'd1};
    begin_program();
    regv[1] = $urandom();
    regv[2] = $urandom();
    if (regv[1] == regv[2]) begin
      regv[2] = ~regv[1];
    end
    load_reg(1, regv[1]);
    load_reg(2, regv[2]);
    // r8 holds a value that must never reach hex
    emit(encode_imm(OP1_ADDI, 8, 0, 16'h0BAD));
    idx = 0;
    for (i = 0; i < 4; i++) begin
      for (p = 0; p < 3; p++) begin
        emit_marker();
        emit(encode_imm(OP1_ADDI, 4, 0, 16'h5B00 + 16'(idx)));
        emit(encode_imm(brs[i], rt_sel[p], rs_sel[p], 16'd1));
        // skipped when taken
        emit(encode_imm(OP1_SW, 4, 0, HEX_OFS));
        if (!branch_taken(brs[i], regv[rs_sel[p]], regv[rt_sel[p]])) begin
          exp_hex.push_back(hex_t'(32'h5B00 + idx));
        end
        idx++;
      end
    end
    // jal over two poisoned stores, link lands in r10
    emit_marker();
    jal_pc = prog_pc;
    emit(encode_imm(OP1_JAL, 10, 0, 16'((jal_pc + 12) >> 2)));
    emit(encode_imm(OP1_SW, 8, 0, HEX_OFS));
    emit(encode_imm(OP1_SW, 8, 0, HEX_OFS));
    expect_store(10, jal_pc + 4);
    run_program("branch");
  endtask

  initial begin
    reset <= 1'b1;
    void'($urandom(SEED));
    test_reset();
    test_alur();
    test_imm();
    test_mem();
    test_branch();
    $display("checks=%0d mismatches=%0d other_failures=%0d",
             check_count, mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
cpu_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: pipelined_cpu

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - fetch_stage.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_cpu.sv
